/* verilog/sd_adc_pkg.sv */
// ----------------------------------------
// Sample and filter word types; FILT_MAX_W covers DECIMATION_LOG2 up to 8
// ----------------------------------------
`default_nettype none

package sd_adc_pkg;

    // Width of one delivered sample
    localparam int SAMPLE_W   = 16;
    // Filter width 3*L+1 at the largest decimation, L = 8
    localparam int FILT_MAX_W = 25;

    // Unsigned output sample
    typedef logic [SAMPLE_W-1:0]   sample_t;
    // Integrator and comb word, upper bits unused below L = 8
    typedef logic [FILT_MAX_W-1:0] filt_acc_t;

    // Capture FSM states in the FPGA clock domain
    typedef enum logic [1:0] {
        WAIT_RDY_HIGH,
        ACQUIRE,
        TRANSFER,
        WAIT_RDY_LOW
    } capture_state_t;

endpackage

`default_nettype wire

/* verilog/sd_cfg_pkg.sv */
// ----------------------------------------
// Register map of the configuration port; COUNT and STATUS are read only
// ----------------------------------------
`default_nettype none

package sd_cfg_pkg;

    // Register address and data word
    typedef logic [1:0]  cfg_addr_t;
    typedef logic [15:0] cfg_data_t;

    // Register addresses
    localparam cfg_addr_t ADDR_CTRL   = 2'd0;
    localparam cfg_addr_t ADDR_OFFSET = 2'd1;
    localparam cfg_addr_t ADDR_COUNT  = 2'd2;
    localparam cfg_addr_t ADDR_STATUS = 2'd3;

    // Bit positions inside CTRL and STATUS
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int STATUS_FLAG_BIT = 0;

endpackage

`default_nettype wire

/* verilog/sinc3_decimator.sv */
// ----------------------------------------
// Runs on the modulator clock; DECIMATION_LOG2 from 4 to 8 only
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sinc3_decimator #(
    parameter int DECIMATION_LOG2 = 8
) (
    input  logic                adc_clk_i,
    input  logic                reset_i,
    input  logic                mdata_i,
    output sd_adc_pkg::sample_t data_o,
    output logic                data_rdy_o
);

    // ----------------------------------------
    // Filter width and wrap mask
    // ----------------------------------------

    // Sinc3 gain is 2^(3L), so 3L+1 bits hold the full scale
    localparam int FILT_W = 3 * DECIMATION_LOG2 + 1;
    localparam sd_adc_pkg::filt_acc_t FILT_MASK =
        sd_adc_pkg::filt_acc_t'((32'd1 << FILT_W) - 32'd1);

    // Integrator chain
    sd_adc_pkg::filt_acc_t int1;
    sd_adc_pkg::filt_acc_t int2;
    sd_adc_pkg::filt_acc_t int3;

    // Comb delay elements, updated at the decimated rate
    sd_adc_pkg::filt_acc_t int3_dly;
    sd_adc_pkg::filt_acc_t comb1_dly;
    sd_adc_pkg::filt_acc_t comb2_dly;

    // Comb differences
    sd_adc_pkg::filt_acc_t comb1;
    sd_adc_pkg::filt_acc_t comb2;
    sd_adc_pkg::filt_acc_t comb3;

    // Decimation counter
    logic [DECIMATION_LOG2-1:0] dec_cnt;
    logic [DECIMATION_LOG2-1:0] dec_cnt_nxt;
    logic                       boundary;

    // Final stage scaled to the sample width
    sd_adc_pkg::sample_t scaled;

    // Keeps arithmetic modulo 2^FILT_W inside the wide word
    function automatic sd_adc_pkg::filt_acc_t wrap(input sd_adc_pkg::filt_acc_t value);
        return value & FILT_MASK;
    endfunction

    // ----------------------------------------
    // Integrators at the modulator rate
    // ----------------------------------------

    // Each stage adds the previous value of the stage before it
    always_ff @(posedge adc_clk_i)
    begin
        if (reset_i)
        begin
            int1 <= '0;
            int2 <= '0;
            int3 <= '0;
        end
        else
        begin
            int1 <= wrap(int1 + sd_adc_pkg::filt_acc_t'(mdata_i));
            int2 <= wrap(int2 + int1);
            int3 <= wrap(int3 + int2);
        end
    end

    // ----------------------------------------
    // Combs and output word
    // ----------------------------------------

    assign dec_cnt_nxt = dec_cnt + 1'b1;
    // Last modulator clock of the decimation period
    assign boundary    = &dec_cnt;

    // Differences against the values held at the previous boundary
    assign comb1 = wrap(int3 - int3_dly);
    assign comb2 = wrap(comb1 - comb1_dly);
    assign comb3 = wrap(comb2 - comb2_dly);

    // Wide filters drop low bits, narrow ones are padded at the bottom
    generate
        if (FILT_W >= sd_adc_pkg::SAMPLE_W)
        begin : g_trunc
            assign scaled = sd_adc_pkg::sample_t'(comb3 >> (FILT_W - sd_adc_pkg::SAMPLE_W));
        end
        else
        begin : g_pad
            assign scaled = sd_adc_pkg::sample_t'(comb3 << (sd_adc_pkg::SAMPLE_W - FILT_W));
        end
    endgenerate

    always_ff @(posedge adc_clk_i)
    begin
        if (reset_i)
        begin
            dec_cnt    <= '0;
            int3_dly   <= '0;
            comb1_dly  <= '0;
            comb2_dly  <= '0;
            data_o     <= '0;
            data_rdy_o <= 1'b0;
        end
        else
        begin
            dec_cnt <= dec_cnt_nxt;
            if (boundary)
            begin
                // New word and ready rise on the same edge
                int3_dly   <= int3;
                comb1_dly  <= comb1;
                comb2_dly  <= comb2;
                data_o     <= scaled;
                data_rdy_o <= 1'b1;
            end
            else if (dec_cnt_nxt[DECIMATION_LOG2-1])
            begin
                // Counter top bit ends the ready level at half period
                data_rdy_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/sample_capture.sv */
// ----------------------------------------
// FPGA clock domain; filt_data_i must hold while the ready level is high
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sample_capture (
    input  logic                fpga_clk_i,
    input  logic                reset_i,
    input  sd_adc_pkg::sample_t filt_data_i,
    input  logic                filt_rdy_i,
    input  logic                enable_i,
    input  sd_adc_pkg::sample_t offset_i,
    output sd_adc_pkg::sample_t data_o,
    output logic                data_rd_ready_o,
    output logic                adc_status_o
);

    // Ready level synchronizer
    logic rdy_meta;
    logic rdy_sync;

    // Capture FSM
    sd_adc_pkg::capture_state_t state;
    sd_adc_pkg::capture_state_t state_nxt;

    // Offset corrected filter word
    sd_adc_pkg::sample_t corrected;

    // ----------------------------------------
    // Clock domain crossing
    // ----------------------------------------

    // Only the ready level is synchronized
    // The data word is stable by the time the FSM reads it
    always_ff @(posedge fpga_clk_i)
    begin
        if (reset_i)
        begin
            rdy_meta <= 1'b0;
            rdy_sync <= 1'b0;
        end
        else
        begin
            rdy_meta <= filt_rdy_i;
            rdy_sync <= rdy_meta;
        end
    end

    // Subtract offset, saturate at zero
    assign corrected = (filt_data_i >= offset_i) ? (filt_data_i - offset_i) : '0;

    // ----------------------------------------
    // Capture FSM
    // ----------------------------------------

    always_comb
    begin
        state_nxt = state;
        case (state)
            sd_adc_pkg::WAIT_RDY_HIGH:
            begin
                // Skipped samples go straight to the low wait
                if (rdy_sync)
                begin
                    state_nxt = enable_i ? sd_adc_pkg::ACQUIRE : sd_adc_pkg::WAIT_RDY_LOW;
                end
            end
            sd_adc_pkg::ACQUIRE:
            begin
                state_nxt = sd_adc_pkg::TRANSFER;
            end
            sd_adc_pkg::TRANSFER:
            begin
                state_nxt = sd_adc_pkg::WAIT_RDY_LOW;
            end
            sd_adc_pkg::WAIT_RDY_LOW:
            begin
                if (!rdy_sync)
                begin
                    state_nxt = sd_adc_pkg::WAIT_RDY_HIGH;
                end
            end
            default:
            begin
                state_nxt = sd_adc_pkg::WAIT_RDY_HIGH;
            end
        endcase
    end

    // Outputs are registered from the current state
    always_ff @(posedge fpga_clk_i)
    begin
        if (reset_i)
        begin
            state           <= sd_adc_pkg::WAIT_RDY_HIGH;
            data_o          <= '0;
            data_rd_ready_o <= 1'b0;
            adc_status_o    <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            case (state)
                sd_adc_pkg::ACQUIRE:
                begin
                    data_o          <= corrected;
                    data_rd_ready_o <= 1'b0;
                    // Sticky until reset
                    adc_status_o    <= 1'b1;
                end
                sd_adc_pkg::TRANSFER:
                begin
                    // Single cycle pulse, data_o already valid
                    data_rd_ready_o <= 1'b1;
                end
                default:
                begin
                    data_rd_ready_o <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/adc_cfg_regs.sv */
// ----------------------------------------
// Writes to COUNT and STATUS are ignored; reads are combinational
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module adc_cfg_regs (
    input  logic                  fpga_clk_i,
    input  logic                  reset_i,
    input  logic                  cfg_we_i,
    input  sd_cfg_pkg::cfg_addr_t cfg_addr_i,
    input  sd_cfg_pkg::cfg_data_t cfg_wdata_i,
    output sd_cfg_pkg::cfg_data_t cfg_rdata_o,
    input  logic                  sample_strobe_i,
    input  logic                  status_i,
    output logic                  enable_o,
    output sd_adc_pkg::sample_t   offset_o
);

    // Delivered samples, wraps at 16 bits
    sd_cfg_pkg::cfg_data_t count;

    // ----------------------------------------
    // Writable registers and counter
    // ----------------------------------------

    always_ff @(posedge fpga_clk_i)
    begin
        if (reset_i)
        begin
            enable_o <= 1'b0;
            offset_o <= '0;
            count    <= '0;
        end
        else
        begin
            if (cfg_we_i && (cfg_addr_i == sd_cfg_pkg::ADDR_CTRL))
            begin
                enable_o <= cfg_wdata_i[sd_cfg_pkg::CTRL_ENABLE_BIT];
            end
            if (cfg_we_i && (cfg_addr_i == sd_cfg_pkg::ADDR_OFFSET))
            begin
                offset_o <= sd_adc_pkg::sample_t'(cfg_wdata_i);
            end
            // One count per ready pulse
            if (sample_strobe_i)
            begin
                count <= count + 1'b1;
            end
        end
    end

    // Read mux, unused bits read as zero
    always_comb
    begin
        cfg_rdata_o = '0;
        case (cfg_addr_i)
            sd_cfg_pkg::ADDR_CTRL:   cfg_rdata_o[sd_cfg_pkg::CTRL_ENABLE_BIT] = enable_o;
            sd_cfg_pkg::ADDR_OFFSET: cfg_rdata_o = sd_cfg_pkg::cfg_data_t'(offset_o);
            sd_cfg_pkg::ADDR_COUNT:  cfg_rdata_o = count;
            default:                 cfg_rdata_o[sd_cfg_pkg::STATUS_FLAG_BIT] = status_i;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/sd_adc_top.sv */
// ----------------------------------------
// adc_clk_i slower than fpga_clk_i; hold reset_i over two modulator edges
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sd_adc_top #(
    parameter int DECIMATION_LOG2 = 8
) (
    input  logic                  fpga_clk_i,
    input  logic                  adc_clk_i,
    input  logic                  reset_i,
    input  logic                  adc_mdata_i,
    input  logic                  cfg_we_i,
    input  sd_cfg_pkg::cfg_addr_t cfg_addr_i,
    input  sd_cfg_pkg::cfg_data_t cfg_wdata_i,
    output sd_cfg_pkg::cfg_data_t cfg_rdata_o,
    output sd_adc_pkg::sample_t   data_o,
    output logic                  data_rd_ready_o,
    output logic                  adc_status_o
);

    // Modulator clock domain
    sd_adc_pkg::sample_t filt_data;
    logic                filt_rdy;

    // Configuration to capture
    logic                enable;
    sd_adc_pkg::sample_t offset;

    // ----------------------------------------
    // Decimation filter
    // ----------------------------------------

    sinc3_decimator #(
        .DECIMATION_LOG2 (DECIMATION_LOG2)
    ) u_sinc3_decimator (
        .adc_clk_i  (adc_clk_i),
        .reset_i    (reset_i),
        .mdata_i    (adc_mdata_i),
        .data_o     (filt_data),
        .data_rdy_o (filt_rdy)
    );

    // ----------------------------------------
    // Capture and registers
    // ----------------------------------------

    sample_capture u_sample_capture (
        .fpga_clk_i      (fpga_clk_i),
        .reset_i         (reset_i),
        .filt_data_i     (filt_data),
        .filt_rdy_i      (filt_rdy),
        .enable_i        (enable),
        .offset_i        (offset),
        .data_o          (data_o),
        .data_rd_ready_o (data_rd_ready_o),
        .adc_status_o    (adc_status_o)
    );

    // Ready pulse doubles as the sample count strobe
    adc_cfg_regs u_adc_cfg_regs (
        .fpga_clk_i      (fpga_clk_i),
        .reset_i         (reset_i),
        .cfg_we_i        (cfg_we_i),
        .cfg_addr_i      (cfg_addr_i),
        .cfg_wdata_i     (cfg_wdata_i),
        .cfg_rdata_o     (cfg_rdata_o),
        .sample_strobe_i (data_rd_ready_o),
        .status_i        (adc_status_o),
        .enable_o        (enable),
        .offset_o        (offset)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// ----------------------------------------
// Free running clock, first rising edge at half a period
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    // Even period only, half period toggles
    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2);
            clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_sd_adc_top.sv */
// ----------------------------------------
// Runs DECIMATION_LOG2 = 4; config writes land only right after a filter output
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_sd_adc_top;

    localparam int DEC_LOG2   = 4;
    localparam int DEC_FACTOR = 1 << DEC_LOG2;
    // Filter word width and scaling toward 16 bits
    localparam int FILT_W     = 3 * DEC_LOG2 + 1;
    localparam int DROP_BITS  = (FILT_W > sd_adc_pkg::SAMPLE_W) ? FILT_W - sd_adc_pkg::SAMPLE_W : 0;
    localparam int PAD_BITS   = (FILT_W < sd_adc_pkg::SAMPLE_W) ? sd_adc_pkg::SAMPLE_W - FILT_W : 0;
    localparam logic [31:0] FILT_MASK = (32'd1 << FILT_W) - 32'd1;

    // Filter outputs consumed per phase: enabled, offset, disable window
    localparam int RUN1_SAMPLES   = 40;
    localparam int RUN2_SAMPLES   = 24;
    localparam int RUN3_SAMPLES   = 14;
    localparam int NUM_OUTPUTS    = RUN1_SAMPLES + RUN2_SAMPLES + RUN3_SAMPLES;
    // 2.5 FPGA cycles per modulator clock
    localparam int TIMEOUT_CYCLES = NUM_OUTPUTS * DEC_FACTOR * 5 / 2 + 200;

    // DUT ports
    logic                  fpga_clk_i;
    logic                  adc_clk_i;
    logic                  reset_i;
    logic                  adc_mdata_i;
    logic                  cfg_we_i;
    sd_cfg_pkg::cfg_addr_t cfg_addr_i;
    sd_cfg_pkg::cfg_data_t cfg_wdata_i;
    sd_cfg_pkg::cfg_data_t cfg_rdata_o;
    sd_adc_pkg::sample_t   data_o;
    logic                  data_rd_ready_o;
    logic                  adc_status_o;

    integer      seed = 32'h16b3f66c;
    logic [31:0] mdata_rnd;

    // Filter model state, modulator domain
    logic [31:0] mi1;
    logic [31:0] mi2;
    logic [31:0] mi3;
    logic [31:0] md3;
    logic [31:0] md1;
    logic [31:0] md2;
    logic [31:0] m_c1;
    logic [31:0] m_c2;
    logic [31:0] m_c3;
    int          m_phase;

    // Raw model outputs and expected deliveries
    sd_adc_pkg::sample_t raw_q[$];
    sd_adc_pkg::sample_t exp_q[$];
    logic                enable_shadow;
    sd_adc_pkg::sample_t offset_shadow;
    int                  pulse_count;
    int                  cycle_count;

    tb_clock_gen #(.PERIOD_NS(40))  u_fpga_clk (.clk_o(fpga_clk_i));
    tb_clock_gen #(.PERIOD_NS(100)) u_adc_clk  (.clk_o(adc_clk_i));

    sd_adc_top #(
        .DECIMATION_LOG2 (DEC_LOG2)
    ) u_sd_adc_top (
        .fpga_clk_i      (fpga_clk_i),
        .adc_clk_i       (adc_clk_i),
        .reset_i         (reset_i),
        .adc_mdata_i     (adc_mdata_i),
        .cfg_we_i        (cfg_we_i),
        .cfg_addr_i      (cfg_addr_i),
        .cfg_wdata_i     (cfg_wdata_i),
        .cfg_rdata_o     (cfg_rdata_o),
        .data_o          (data_o),
        .data_rd_ready_o (data_rd_ready_o),
        .adc_status_o    (adc_status_o)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_sample(input string name, input sd_adc_pkg::sample_t expected,
                                input sd_adc_pkg::sample_t actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("FAIL time %0t signal %s expected 0x%04h actual 0x%04h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_reg(input string name, input sd_cfg_pkg::cfg_data_t expected,
                             input sd_cfg_pkg::cfg_data_t actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("FAIL time %0t signal %s expected 0x%04h actual 0x%04h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("FAIL time %0t signal %s expected %b actual %b",
                                $time, name, expected, actual));
        end
    endtask

    // Drives at the current rising edge, strobe lasts one cycle
    task automatic write_reg(input sd_cfg_pkg::cfg_addr_t addr, input sd_cfg_pkg::cfg_data_t wdata);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= wdata;
        @(posedge fpga_clk_i);
        cfg_we_i    <= 1'b0;
    endtask

    // Read port is combinational, sampled one edge after the address
    task automatic read_reg(input sd_cfg_pkg::cfg_addr_t addr, output sd_cfg_pkg::cfg_data_t data);
        @(posedge fpga_clk_i);
        cfg_addr_i <= addr;
        @(posedge fpga_clk_i);
        data = cfg_rdata_o;
    endtask

    // Returns on the first FPGA edge after a model output
    task automatic take_output(output sd_adc_pkg::sample_t raw);
        while (raw_q.size() == 0)
        begin
            @(posedge fpga_clk_i);
        end
        raw = raw_q.pop_front();
    endtask

    // Offset rule, clamped at zero
    function automatic sd_adc_pkg::sample_t apply_offset(input sd_adc_pkg::sample_t raw,
                                                         input sd_adc_pkg::sample_t off);
        if (raw >= off)
        begin
            return raw - off;
        end
        return '0;
    endfunction

    // Enabled samples are queued and their ready pulse awaited
    task automatic deliver_or_drop(input sd_adc_pkg::sample_t raw);
        int prev;
        prev = pulse_count;
        if (enable_shadow)
        begin
            exp_q.push_back(apply_offset(raw, offset_shadow));
            while (pulse_count == prev)
            begin
                @(posedge fpga_clk_i);
            end
        end
    endtask

    function automatic logic [31:0] wrap_filt(input logic [31:0] value);
        return value & FILT_MASK;
    endfunction

    function automatic sd_adc_pkg::sample_t scale_word(input logic [31:0] word);
        logic [31:0] shifted;
        shifted = (word >> DROP_BITS) << PAD_BITS;
        return sd_adc_pkg::sample_t'(shifted);
    endfunction

    // ----------------------------------------
    // Bitstream and filter model
    // ----------------------------------------

    always @(posedge adc_clk_i)
    begin
        mdata_rnd = $random(seed);
        adc_mdata_i <= mdata_rnd[0];
    end

    // Sees the same bit as the DUT at this edge
    always @(posedge adc_clk_i)
    begin
        if (reset_i)
        begin
            mi1     = '0;
            mi2     = '0;
            mi3     = '0;
            md3     = '0;
            md1     = '0;
            md2     = '0;
            m_phase = 0;
        end
        else
        begin
            // Combs at the decimated rate, from the integrator state before this edge
            if (m_phase == DEC_FACTOR - 1)
            begin
                m_c1 = wrap_filt(mi3 - md3);
                m_c2 = wrap_filt(m_c1 - md1);
                m_c3 = wrap_filt(m_c2 - md2);
                md3  = mi3;
                md1  = m_c1;
                md2  = m_c2;
                raw_q.push_back(scale_word(m_c3));
            end
            // Later stages first, each adds the old value of the stage before
            mi3     = wrap_filt(mi3 + mi2);
            mi2     = wrap_filt(mi2 + mi1);
            mi1     = wrap_filt(mi1 + {31'd0, adc_mdata_i});
            m_phase = (m_phase + 1) % DEC_FACTOR;
        end
    end

    // ----------------------------------------
    // Output monitor and watchdog
    // ----------------------------------------

    always @(posedge fpga_clk_i)
    begin
        if (data_rd_ready_o)
        begin
            if (exp_q.size() == 0)
            begin
                abort_run("data_rd_ready_o pulsed while no sample was expected");
            end
            else
            begin
                check_sample("data_o", exp_q.pop_front(), data_o);
                pulse_count++;
            end
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge fpga_clk_i);
            cycle_count++;
        end
        abort_run($sformatf("timeout after %0d FPGA cycles", TIMEOUT_CYCLES));
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial
    begin : main_sequence
        sd_adc_pkg::sample_t   raw;
        sd_adc_pkg::sample_t   off_val;
        sd_cfg_pkg::cfg_data_t rd;
        logic [31:0]           rnd;
        int                    prev;

        reset_i       = 1'b1;
        adc_mdata_i   = 1'b0;
        cfg_we_i      = 1'b0;
        cfg_addr_i    = sd_cfg_pkg::ADDR_CTRL;
        cfg_wdata_i   = '0;
        enable_shadow = 1'b0;
        offset_shadow = '0;
        pulse_count   = 0;
        repeat (5) @(posedge fpga_clk_i);
        reset_i <= 1'b0;

        // Reset values
        check_bit("data_rd_ready_o", 1'b0, data_rd_ready_o);
        check_bit("adc_status_o", 1'b0, adc_status_o);
        read_reg(sd_cfg_pkg::ADDR_CTRL, rd);
        check_reg("CTRL", 16'h0000, rd);
        read_reg(sd_cfg_pkg::ADDR_OFFSET, rd);
        check_reg("OFFSET", 16'h0000, rd);
        read_reg(sd_cfg_pkg::ADDR_COUNT, rd);
        check_reg("COUNT", 16'h0000, rd);
        read_reg(sd_cfg_pkg::ADDR_STATUS, rd);
        check_reg("STATUS", 16'h0000, rd);

        // Enabled, zero offset, first sample is a warm-up value
        for (int i = 0; i < RUN1_SAMPLES; i++)
        begin
            take_output(raw);
            if (i == 0)
            begin
                write_reg(sd_cfg_pkg::ADDR_CTRL, 16'h0001);
                enable_shadow = 1'b1;
            end
            deliver_or_drop(raw);
            if (i == 0)
            begin
                check_bit("adc_status_o", 1'b1, adc_status_o);
                read_reg(sd_cfg_pkg::ADDR_STATUS, rd);
                check_reg("STATUS", 16'h0001, rd);
                read_reg(sd_cfg_pkg::ADDR_CTRL, rd);
                check_reg("CTRL", 16'h0001, rd);
            end
        end

        // Offsets alternate small and above full scale midpoint
        for (int i = 0; i < RUN2_SAMPLES; i++)
        begin
            take_output(raw);
            if (i % 3 == 0)
            begin
                rnd = $random(seed);
                if ((i / 3) % 2 == 0)
                begin
                    off_val = rnd[15:0] & 16'h3fff;
                end
                else
                begin
                    off_val = rnd[15:0] | 16'h8000;
                end
                write_reg(sd_cfg_pkg::ADDR_OFFSET, off_val);
                offset_shadow = off_val;
            end
            deliver_or_drop(raw);
            if (i % 3 == 0)
            begin
                read_reg(sd_cfg_pkg::ADDR_OFFSET, rd);
                check_reg("OFFSET", off_val, rd);
            end
        end

        // Ten filter periods disabled, then delivery resumes
        prev = pulse_count;
        for (int i = 0; i < RUN3_SAMPLES; i++)
        begin
            take_output(raw);
            if (i == 0)
            begin
                write_reg(sd_cfg_pkg::ADDR_CTRL, 16'h0000);
                enable_shadow = 1'b0;
            end
            else if (i == 1)
            begin
                write_reg(sd_cfg_pkg::ADDR_OFFSET, 16'h0000);
                offset_shadow = '0;
            end
            else if (i == 10)
            begin
                write_reg(sd_cfg_pkg::ADDR_CTRL, 16'h0001);
                enable_shadow = 1'b1;
            end
            deliver_or_drop(raw);
            if (i == 1)
            begin
                read_reg(sd_cfg_pkg::ADDR_CTRL, rd);
                check_reg("CTRL", 16'h0000, rd);
            end
            if (i == 10)
            begin
                read_reg(sd_cfg_pkg::ADDR_COUNT, rd);
                check_reg("COUNT", sd_cfg_pkg::cfg_data_t'(prev + 1), rd);
            end
        end

        // Counter matches observed pulses, read-only registers hold
        read_reg(sd_cfg_pkg::ADDR_COUNT, rd);
        check_reg("COUNT", sd_cfg_pkg::cfg_data_t'(pulse_count), rd);
        rnd = $random(seed);
        write_reg(sd_cfg_pkg::ADDR_COUNT, rnd[15:0]);
        write_reg(sd_cfg_pkg::ADDR_STATUS, 16'h0000);
        read_reg(sd_cfg_pkg::ADDR_COUNT, rd);
        check_reg("COUNT", sd_cfg_pkg::cfg_data_t'(pulse_count), rd);
        read_reg(sd_cfg_pkg::ADDR_STATUS, rd);
        check_reg("STATUS", 16'h0001, rd);

        if (exp_q.size() != 0)
        begin
            abort_run($sformatf("%0d expected samples were never delivered", exp_q.size()));
        end
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* compile.f */
verilog/sd_adc_pkg.sv
verilog/sd_cfg_pkg.sv
verilog/sinc3_decimator.sv
verilog/sample_capture.sv
verilog/adc_cfg_regs.sv
verilog/sd_adc_top.sv
testbench/tb_clock_gen.sv
testbench/tb_sd_adc_top.sv

/* Makefile */
# Verilator build and run of the sigma-delta ADC testbench
# Override any variable on the command line, e.g. make run TOP=tb_sd_adc_top

VERILATOR ?= verilator
TOP       ?= tb_sd_adc_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j $(JOBS)

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-o V$(TOP) -f $(FILELIST)

# The exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
